// ==== dv/resample_iq_vectors.txt ====
# Columns: test id, kind, then four hex fields a b c d.
# cmd: a opcode (1 set int, 2 set dec, 3 apply), b rate. in/rnd: a I, b Q, c samples, d spacing.
# exp: a check (0 flags b=error c=pending, 1 count b, 2 dc b=I c=Q skip d,
#      3 output d equals b=I c=Q, 4 dc of the random pair skip d, 5 restart output count).
1 in 0123 fedc 1 2
1 in 7fff 8000 1 2
1 in 0000 0001 1 2
1 exp 1 3 0 0
1 exp 3 0123 fedc 0
1 exp 3 7fff 8000 1
1 exp 3 0000 0001 2
2 cmd 1 4 0 0
2 cmd 2 2 0 0
2 exp 0 0 1 0
2 cmd 3 0 0 0
2 exp 0 0 0 0
2 in 04d2 f830 10 4
2 exp 1 20 0 0
2 exp 2 04d2 f830 10
3 cmd 1 2 0 0
3 cmd 2 8 0 0
3 cmd 3 0 0 0
3 in 03e8 fc18 10 2
3 exp 1 4 0 0
3 exp 2 03e8 fc18 3
4 cmd 1 1 0 0
4 cmd 2 1 0 0
4 cmd 3 0 0 0
4 cmd 1 3 0 0
4 exp 0 1 0 0
4 cmd 3 0 0 0
4 exp 0 0 0 0
4 in 0555 0aaa 2 2
4 exp 1 2 0 0
4 exp 2 0555 0aaa 0
4 cmd 2 0 0 0
4 cmd 1 100 0 0
4 exp 0 1 0 0
4 cmd 3 0 0 0
4 exp 0 0 0 0
4 cmd 1 1 0 0
4 exp 0 0 1 0
4 cmd 3 0 0 0
5 cmd 1 8 0 0
5 cmd 2 4 0 0
5 cmd 3 0 0 0
5 rnd 0 0 c 8
5 exp 1 18 0 0
5 exp 4 0 0 c
6 cmd 1 2 0 0
6 cmd 2 2 0 0
6 cmd 3 0 0 0
6 in 01f4 0064 8 2
6 cmd 1 4 0 0
6 cmd 2 1 0 0
6 cmd 3 0 0 0
6 exp 5 0 0 0
6 in fed4 012c 8 4
6 exp 1 20 0 0
6 exp 2 fed4 012c 10

// ==== resample_iq_top.f ====
hw/resample_cfg_pkg.sv
hw/cic_pkg.sv
hw/resample_rate_regs.sv
hw/cic_interpolate.sv
hw/cic_decimate.sv
hw/resample_iq.sv
hw/resample_iq_top.sv
dv/resample_iq_asserts.sv
dv/resample_iq_tb.sv

// ==== Bender.yml ====
package:
  name: resample_iq

sources:
  - files:
      - hw/resample_cfg_pkg.sv
      - hw/cic_pkg.sv
      - hw/resample_rate_regs.sv
      - hw/cic_interpolate.sv
      - hw/cic_decimate.sv
      - hw/resample_iq.sv
      - hw/resample_iq_top.sv
  - target: test
    files:
      - dv/resample_iq_asserts.sv
      - dv/resample_iq_tb.sv

// ==== dv/resample_iq_tb.sv ====
module resample_iq_tb;

  localparam int DATA_WIDTH = 16;
  localparam int N = 4;
  localparam int LATENCY = 2 * N + 2; // Each CIC stage takes N + 1 cycles.
  localparam int GUARD_CYCLES = 24; // Long enough for any stray strobe to show up.
  localparam int WAIT_LIMIT = 1024;

  logic                      clk;
  logic                      reset;
  logic                      cfg_valid;
  resample_cfg_pkg::cfg_op_e cfg_op;
  logic [8:0]                cfg_rate;
  logic                      strobe_in;
  logic [DATA_WIDTH-1:0]     in_itdata;
  logic [DATA_WIDTH-1:0]     in_qtdata;
  logic                      strobe_out;
  logic [DATA_WIDTH-1:0]     out_itdata;
  logic [DATA_WIDTH-1:0]     out_qtdata;
  logic                      cfg_error;
  logic                      cfg_pending;

  int                    vec_id[$];
  string                 vec_kind[$];
  int                    vec_a[$];
  int                    vec_b[$];
  int                    vec_c[$];
  int                    vec_d[$];
  logic [DATA_WIDTH-1:0] got_i[$];
  logic [DATA_WIDTH-1:0] got_q[$];
  int                    in_cycle[$];
  int                    out_cycle[$];
  logic [DATA_WIDTH-1:0] rnd_i;
  logic [DATA_WIDTH-1:0] rnd_q;
  integer                seed = 32'h6088ce59;
  int                    errors;
  int                    test_errors;
  int                    tests_run;
  int                    tests_failed;
  int                    cur_test;
  int                    cycles;
  int                    cycle_limit;

  resample_iq_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .cfg_valid   (cfg_valid),
    .cfg_op      (cfg_op),
    .cfg_rate    (cfg_rate),
    .strobe_in   (strobe_in),
    .in_itdata   (in_itdata),
    .in_qtdata   (in_qtdata),
    .strobe_out  (strobe_out),
    .out_itdata  (out_itdata),
    .out_qtdata  (out_qtdata),
    .cfg_error   (cfg_error),
    .cfg_pending (cfg_pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles in test %0d", cycles, cur_test);
      $display("Some tests failed");
      $finish;
    end
  end

  // Outputs are registered, so the values seen at the edge are the settled ones.
  always @(posedge clk) begin
    if (!reset && strobe_out) begin
      got_i.push_back(out_itdata);
      got_q.push_back(out_qtdata);
      out_cycle.push_back(cycles);
    end
  end

  task automatic check_sample(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_vectors();
    int    fd;
    string line;
    string kind;
    int    id;
    int    a;
    int    b;
    int    c;
    int    d;
    fd = $fopen("dv/resample_iq_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file dv/resample_iq_vectors.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;
        if ($sscanf(line, "%d %s %h %h %h %h", id, kind, a, b, c, d) == 6) begin
          vec_id.push_back(id);
          vec_kind.push_back(kind);
          vec_a.push_back(a);
          vec_b.push_back(b);
          vec_c.push_back(c);
          vec_d.push_back(d);
        end
      end
      $fclose(fd);
      if (vec_id.size() == 0) begin
        $display("The vector file dv/resample_iq_vectors.txt holds no vectors");
        errors++;
      end
    end
  endtask

  task automatic send_cmd(input int op, input int rate);
    cfg_valid = 1'b1;
    cfg_op    = resample_cfg_pkg::cfg_op_e'(op[1:0]);
    cfg_rate  = rate[8:0];
    @(negedge clk);
    cfg_valid = 1'b0;
    cfg_op    = resample_cfg_pkg::CFG_NOP;
    cfg_rate  = '0;
    if (op == 3) repeat (2) @(negedge clk); // rate_stb cycle, then the flush cycle.
  endtask

  task automatic drive_samples(input logic [DATA_WIDTH-1:0] i, input logic [DATA_WIDTH-1:0] q,
                               input int count, input int spacing);
    for (int j = 0; j < count; j++) begin
      strobe_in = 1'b1;
      in_itdata = i;
      in_qtdata = q;
      in_cycle.push_back(cycles);
      @(negedge clk);
      strobe_in = 1'b0;
      repeat (spacing - 1) @(negedge clk);
    end
  endtask

  task automatic clear_outputs();
    got_i.delete();
    got_q.delete();
    in_cycle.delete();
    out_cycle.delete();
  endtask

  task automatic wait_outputs(input int n);
    int waited;
    waited = 0;
    while (got_i.size() < n && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (got_i.size() < n) begin
      $display("Test %0d ended with only %0d of %0d expected strobe_out pulses",
               cur_test, got_i.size(), n);
      errors++;
      test_errors++;
    end else begin
      repeat (GUARD_CYCLES) @(negedge clk);
      check_count("strobe_out count", n, got_i.size());
    end
  endtask

  task automatic check_dc(input logic [DATA_WIDTH-1:0] i, input logic [DATA_WIDTH-1:0] q,
                          input int skip);
    if (got_i.size() <= skip) begin
      $display("Test %0d has no settled outputs after skipping %0d", cur_test, skip);
      errors++;
      test_errors++;
    end
    for (int k = skip; k < got_i.size(); k++) begin
      check_sample("out_itdata", i, got_i[k]);
      check_sample("out_qtdata", q, got_q[k]);
    end
  endtask

  task automatic run_entry(input int k);
    if (vec_kind[k] == "cmd") begin
      send_cmd(vec_a[k], vec_b[k]);
    end else if (vec_kind[k] == "in") begin
      drive_samples(DATA_WIDTH'(vec_a[k]), DATA_WIDTH'(vec_b[k]), vec_c[k], vec_d[k]);
    end else if (vec_kind[k] == "rnd") begin
      rnd_i = DATA_WIDTH'($random(seed));
      rnd_q = DATA_WIDTH'($random(seed));
      drive_samples(rnd_i, rnd_q, vec_c[k], vec_d[k]);
    end else if (vec_kind[k] == "exp") begin
      case (vec_a[k])
        0: begin
          check_flag("cfg_error", vec_b[k] != 0, cfg_error);
          check_flag("cfg_pending", vec_c[k] != 0, cfg_pending);
        end
        1: wait_outputs(vec_b[k]);
        2: check_dc(DATA_WIDTH'(vec_b[k]), DATA_WIDTH'(vec_c[k]), vec_d[k]);
        3: begin
          // These run on a 1:1 stream, where output d answers input d.
          if (vec_d[k] >= got_i.size() || vec_d[k] >= in_cycle.size()) begin
            $display("Test %0d is missing output number %0d", cur_test, vec_d[k]);
            errors++;
            test_errors++;
          end else begin
            check_sample("out_itdata", DATA_WIDTH'(vec_b[k]), got_i[vec_d[k]]);
            check_sample("out_qtdata", DATA_WIDTH'(vec_c[k]), got_q[vec_d[k]]);
            check_count("strobe_out latency", LATENCY,
                        out_cycle[vec_d[k]] - in_cycle[vec_d[k]]);
          end
        end
        4: check_dc(rnd_i, rnd_q, vec_d[k]);
        5: clear_outputs();
        default: begin
          $display("Vector line of test %0d has an unknown check type", cur_test);
          errors++;
        end
      endcase
    end else begin
      $display("Vector line of test %0d has an unknown kind %s", cur_test, vec_kind[k]);
      errors++;
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %0d finished with %0d errors", cur_test, test_errors);
  endtask

  initial begin
    int rate;
    reset       = 1'b1;
    cfg_valid   = 1'b0;
    cfg_op      = resample_cfg_pkg::CFG_NOP;
    cfg_rate    = '0;
    strobe_in   = 1'b0;
    in_itdata   = '0;
    in_qtdata   = '0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    tests_failed = 0;
    cycles      = 0;
    cur_test    = -1;
    cycle_limit = 200;
    load_vectors();
    rate = 1;
    for (int k = 0; k < vec_id.size(); k++) begin
      if (vec_kind[k] == "cmd" && vec_a[k] == 1) rate = (vec_b[k] > 1) ? vec_b[k] : 1;
      if (vec_kind[k] == "in" || vec_kind[k] == "rnd") cycle_limit += vec_c[k] * rate * 4;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk); // The filters flush on the first cycle out of reset.
    for (int k = 0; k < vec_id.size(); k++) begin
      if (vec_id[k] != cur_test) begin
        if (cur_test >= 0) finish_test();
        cur_test    = vec_id[k];
        test_errors = 0;
        clear_outputs();
      end
      run_entry(k);
    end
    if (cur_test >= 0) finish_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== dv/resample_iq_asserts.sv ====
module resample_iq_asserts #(
  parameter RATE_W = 8
) (
  input logic              clk,
  input logic              reset,
  input logic              strobe_in,
  input logic              rate_stb,
  input logic              cfg_error,
  input logic [RATE_W-1:0] rate_int
);

  logic [15:0] gap; // Cycles since the last input strobe, saturating.

  always_ff @(posedge clk) begin
    if (reset) begin
      gap <= '1;
    end else if (strobe_in) begin
      gap <= 16'd1;
    end else if (gap != '1) begin
      gap <= gap + 1'b1;
    end
  end

  rate_stb_one_cycle: assert property (@(posedge clk) disable iff (reset)
    rate_stb |=> !rate_stb) else $error("rate_stb stayed high for more than one cycle");

  // The interpolator burst must end before the next input arrives.
  strobe_spacing: assert property (@(posedge clk) disable iff (reset)
    strobe_in |-> gap >= rate_int) else $error("strobe_in closer than rate_int cycles");

  // A rate strobe answers an apply, and an apply made in error applies nothing.
  no_apply_in_error: assert property (@(posedge clk) disable iff (reset)
    rate_stb |-> !$past(cfg_error)) else $error("rate_stb issued for an apply made in error");

endmodule

bind resample_iq_top resample_iq_asserts #(.RATE_W($clog2(MAX_RATE_INT + 1))) asserts0 (
  .clk       (clk),
  .reset     (reset),
  .strobe_in (strobe_in),
  .rate_stb  (rate_stb),
  .cfg_error (cfg_error),
  .rate_int  (rate_int)
);

// ==== hw/resample_iq_top.sv ====
module resample_iq_top #(
  parameter DATA_WIDTH = 16,
  parameter N = 4,
  parameter MAX_RATE_DEC = 256,
  parameter MAX_RATE_INT = 128,
  // The command word must hold the larger of the two rate maxima.
  localparam int CFG_RATE_W = (MAX_RATE_DEC > MAX_RATE_INT) ?
                              $clog2(MAX_RATE_DEC + 1) : $clog2(MAX_RATE_INT + 1)
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cfg_valid,
  input  resample_cfg_pkg::cfg_op_e  cfg_op,
  input  logic [CFG_RATE_W-1:0]      cfg_rate,
  input  logic                       strobe_in,
  input  logic [DATA_WIDTH-1:0]      in_itdata,
  input  logic [DATA_WIDTH-1:0]      in_qtdata,
  output logic                       strobe_out,
  output logic [DATA_WIDTH-1:0]      out_itdata,
  output logic [DATA_WIDTH-1:0]      out_qtdata,
  output logic                       cfg_error,
  output logic                       cfg_pending
);

  logic                               rate_stb;
  logic [$clog2(MAX_RATE_INT+1)-1:0]  rate_int;
  logic [$clog2(MAX_RATE_DEC+1)-1:0]  rate_dec;
  cic_pkg::log2_rate_t                shift_int;
  cic_pkg::log2_rate_t                shift_dec;

  resample_rate_regs #(
    .MAX_RATE_DEC (MAX_RATE_DEC),
    .MAX_RATE_INT (MAX_RATE_INT),
    .CFG_RATE_W   (CFG_RATE_W)
  ) rate_regs0 (
    .clk         (clk),
    .reset       (reset),
    .cfg_valid   (cfg_valid),
    .cfg_op      (cfg_op),
    .cfg_rate    (cfg_rate),
    .rate_stb    (rate_stb),
    .rate_int    (rate_int),
    .rate_dec    (rate_dec),
    .shift_int   (shift_int),
    .shift_dec   (shift_dec),
    .cfg_pending (cfg_pending),
    .cfg_error   (cfg_error)
  );

  resample_iq #(
    .DATA_WIDTH   (DATA_WIDTH),
    .N            (N),
    .MAX_RATE_DEC (MAX_RATE_DEC),
    .MAX_RATE_INT (MAX_RATE_INT)
  ) resample0 (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate_dec   (rate_dec),
    .rate_int   (rate_int),
    .shift_dec  (shift_dec),
    .shift_int  (shift_int),
    .strobe_in  (strobe_in),
    .strobe_out (strobe_out),
    .in_itdata  (in_itdata),
    .in_qtdata  (in_qtdata),
    .out_itdata (out_itdata),
    .out_qtdata (out_qtdata)
  );

endmodule

// ==== hw/resample_iq.sv ====
module resample_iq #(
  parameter DATA_WIDTH = 16,
  parameter N = 4,
  parameter MAX_RATE_DEC = 256,
  parameter MAX_RATE_INT = 128
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                rate_stb,
  input  logic [$clog2(MAX_RATE_DEC+1)-1:0]   rate_dec, // +1 so that the top rate fits.
  input  logic [$clog2(MAX_RATE_INT+1)-1:0]   rate_int,
  input  cic_pkg::log2_rate_t                 shift_dec,
  input  cic_pkg::log2_rate_t                 shift_int,
  input  logic                                strobe_in,
  output logic                                strobe_out,
  input  logic [DATA_WIDTH-1:0]               in_itdata,
  input  logic [DATA_WIDTH-1:0]               in_qtdata,
  output logic [DATA_WIDTH-1:0]               out_itdata,
  output logic [DATA_WIDTH-1:0]               out_qtdata
);

  logic                  int_istrobe;
  logic                  int_qstrobe;
  logic                  idec_strobe_out;
  logic                  qdec_strobe_out;
  logic [DATA_WIDTH-1:0] dec_itdata;
  logic [DATA_WIDTH-1:0] dec_qtdata;

  // Both channels see the same strobes and rates, so they stay in lockstep.
  assign strobe_out = idec_strobe_out & qdec_strobe_out;

  cic_interpolate #(.WIDTH(DATA_WIDTH), .N(N), .MAX_RATE(MAX_RATE_INT)) icic_i (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate       (rate_int),
    .shift      (shift_int),
    .strobe_in  (strobe_in),
    .strobe_out (int_istrobe),
    .signal_in  (in_itdata),
    .signal_out (dec_itdata)
  );

  cic_interpolate #(.WIDTH(DATA_WIDTH), .N(N), .MAX_RATE(MAX_RATE_INT)) icic_q (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate       (rate_int),
    .shift      (shift_int),
    .strobe_in  (strobe_in),
    .strobe_out (int_qstrobe),
    .signal_in  (in_qtdata),
    .signal_out (dec_qtdata)
  );

  cic_decimate #(.WIDTH(DATA_WIDTH), .N(N), .MAX_RATE(MAX_RATE_DEC)) dcic_i (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate       (rate_dec),
    .shift      (shift_dec),
    .strobe_in  (int_istrobe),
    .strobe_out (idec_strobe_out),
    .signal_in  (dec_itdata),
    .signal_out (out_itdata)
  );

  cic_decimate #(.WIDTH(DATA_WIDTH), .N(N), .MAX_RATE(MAX_RATE_DEC)) dcic_q (
    .clk        (clk),
    .reset      (reset),
    .rate_stb   (rate_stb),
    .rate       (rate_dec),
    .shift      (shift_dec),
    .strobe_in  (int_qstrobe),
    .strobe_out (qdec_strobe_out),
    .signal_in  (dec_qtdata),
    .signal_out (out_qtdata)
  );

endmodule

// ==== hw/cic_decimate.sv ====
module cic_decimate #(
  parameter WIDTH = 16,
  parameter N = 4,
  parameter MAX_RATE = 256
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           rate_stb,
  input  logic [$clog2(MAX_RATE+1)-1:0]  rate,
  input  cic_pkg::log2_rate_t            shift,
  input  logic                           strobe_in,
  output logic                           strobe_out,
  input  logic [WIDTH-1:0]               signal_in,
  output logic [WIDTH-1:0]               signal_out
);

  localparam int RATE_W = $clog2(MAX_RATE + 1);
  localparam int GROWTH = N * $clog2(MAX_RATE);
  localparam int ACC_W  = WIDTH + GROWTH;
  localparam int SH_W   = $clog2(GROWTH + 1);

  cic_pkg::cic_phase_e     phase;
  logic                    run_en;
  logic [RATE_W-1:0]       dec_cnt;
  logic                    sample_vld;
  logic [N-1:0]            comb_en;
  logic [N-1:0]            comb_vld;
  logic signed [ACC_W-1:0] integ_next [N];
  logic signed [ACC_W-1:0] integ [N];
  logic signed [ACC_W-1:0] comb_src [N];
  logic signed [ACC_W-1:0] comb_dly [N];
  logic signed [ACC_W-1:0] comb_out [N];
  logic signed [ACC_W-1:0] shifted;
  logic [SH_W-1:0]         gain_shift;

  assign run_en = strobe_in && (phase == cic_pkg::CIC_RUN);

  always_comb begin
    integ_next[0] = integ[0] + ACC_W'($signed(signal_in));
    for (int k = 1; k < N; k++) begin
      integ_next[k] = integ[k] + integ_next[k-1];
    end
  end

  always_comb begin
    comb_en[0]  = sample_vld;
    comb_src[0] = integ[N-1];
    for (int k = 1; k < N; k++) begin
      comb_en[k]  = comb_vld[k-1];
      comb_src[k] = comb_out[k-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= cic_pkg::CIC_FLUSH;
      dec_cnt    <= '0;
      sample_vld <= 1'b0;
      comb_vld   <= '0;
    end else if (phase == cic_pkg::CIC_FLUSH) begin
      phase      <= cic_pkg::CIC_RUN;
      dec_cnt    <= rate - 1'b1; // First output on the rate-th input.
      sample_vld <= 1'b0;
      comb_vld   <= '0;
    end else begin
      if (rate_stb) begin
        phase <= cic_pkg::CIC_FLUSH;
      end
      sample_vld <= run_en && (dec_cnt == '0);
      comb_vld   <= comb_en;
      if (run_en) begin
        dec_cnt <= (dec_cnt == '0) ? rate - 1'b1 : dec_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < N; k++) begin
      if (phase == cic_pkg::CIC_FLUSH) begin
        integ[k]    <= '0;
        comb_dly[k] <= '0;
        comb_out[k] <= '0;
      end else begin
        if (run_en) begin
          integ[k] <= integ_next[k];
        end
        if (comb_en[k]) begin
          comb_out[k] <= comb_src[k] - comb_dly[k];
          comb_dly[k] <= comb_src[k];
        end
      end
    end
  end

  assign strobe_out = comb_vld[N-1];

  // Full decimator gain is rate**N.
  assign gain_shift = SH_W'(shift * N);
  assign shifted    = comb_out[N-1] >>> gain_shift;
  assign signal_out = shifted[WIDTH-1:0];

endmodule

// ==== hw/cic_interpolate.sv ====
module cic_interpolate #(
  parameter WIDTH = 16,
  parameter N = 4,
  parameter MAX_RATE = 128
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           rate_stb,
  input  logic [$clog2(MAX_RATE+1)-1:0]  rate,
  input  cic_pkg::log2_rate_t            shift,
  input  logic                           strobe_in,
  output logic                           strobe_out,
  input  logic [WIDTH-1:0]               signal_in,
  output logic [WIDTH-1:0]               signal_out
);

  localparam int RATE_W = $clog2(MAX_RATE + 1);
  localparam int GROWTH = N * $clog2(MAX_RATE);
  localparam int ACC_W  = WIDTH + GROWTH;
  localparam int SH_W   = $clog2(GROWTH + 1);

  cic_pkg::cic_phase_e     phase;
  logic [N-1:0]            comb_en;
  logic [N-1:0]            comb_vld;
  logic [RATE_W-1:0]       burst_cnt;
  logic                    integ_en;
  logic signed [ACC_W-1:0] comb_src [N];
  logic signed [ACC_W-1:0] comb_dly [N];
  logic signed [ACC_W-1:0] comb_out [N];
  logic signed [ACC_W-1:0] integ_in;
  logic signed [ACC_W-1:0] integ_next [N];
  logic signed [ACC_W-1:0] integ [N];
  logic signed [ACC_W-1:0] shifted;
  logic [SH_W-1:0]         gain_shift;

  always_comb begin
    comb_en[0]  = strobe_in && (phase == cic_pkg::CIC_RUN); // Dropped while flushing.
    comb_src[0] = ACC_W'($signed(signal_in));
    for (int k = 1; k < N; k++) begin
      comb_en[k]  = comb_vld[k-1];
      comb_src[k] = comb_out[k-1];
    end
  end

  // Zero stuffing. The comb result enters on the first burst cycle only.
  assign integ_en = comb_vld[N-1] || (burst_cnt != '0);
  assign integ_in = comb_vld[N-1] ? comb_out[N-1] : '0;

  // All integrators settle in one cycle, so the burst leaves with no extra lag.
  always_comb begin
    integ_next[0] = integ[0] + integ_in;
    for (int k = 1; k < N; k++) begin
      integ_next[k] = integ[k] + integ_next[k-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= cic_pkg::CIC_FLUSH;
      comb_vld   <= '0;
      burst_cnt  <= '0;
      strobe_out <= 1'b0;
    end else if (phase == cic_pkg::CIC_FLUSH) begin
      phase      <= cic_pkg::CIC_RUN;
      comb_vld   <= '0;
      burst_cnt  <= '0;
      strobe_out <= 1'b0;
    end else begin
      if (rate_stb) begin
        phase <= cic_pkg::CIC_FLUSH;
      end
      comb_vld   <= comb_en;
      strobe_out <= integ_en;
      if (comb_vld[N-1]) begin
        burst_cnt <= rate - 1'b1;
      end else if (burst_cnt != '0) begin
        burst_cnt <= burst_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < N; k++) begin
      if (phase == cic_pkg::CIC_FLUSH) begin
        comb_dly[k] <= '0;
        comb_out[k] <= '0;
        integ[k]    <= '0;
      end else begin
        if (comb_en[k]) begin
          comb_out[k] <= comb_src[k] - comb_dly[k];
          comb_dly[k] <= comb_src[k];
        end
        if (integ_en) begin
          integ[k] <= integ_next[k];
        end
      end
    end
  end

  // The interpolator gain is rate**(N-1), removed here by truncation.
  assign gain_shift = SH_W'(shift * (N - 1));
  assign shifted    = integ[N-1] >>> gain_shift;
  assign signal_out = shifted[WIDTH-1:0];

endmodule

// ==== hw/resample_rate_regs.sv ====
module resample_rate_regs #(
  parameter MAX_RATE_DEC = 256,
  parameter MAX_RATE_INT = 128,
  parameter CFG_RATE_W = 9
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               cfg_valid,
  input  resample_cfg_pkg::cfg_op_e          cfg_op,
  input  logic [CFG_RATE_W-1:0]              cfg_rate,
  output logic                               rate_stb,
  output logic [$clog2(MAX_RATE_INT+1)-1:0]  rate_int,
  output logic [$clog2(MAX_RATE_DEC+1)-1:0]  rate_dec,
  output cic_pkg::log2_rate_t                shift_int,
  output cic_pkg::log2_rate_t                shift_dec,
  output logic                               cfg_pending,
  output logic                               cfg_error
);

  localparam int INT_W = $clog2(MAX_RATE_INT + 1);
  localparam int DEC_W = $clog2(MAX_RATE_DEC + 1);

  resample_cfg_pkg::cfg_state_e state;
  logic [INT_W-1:0]             pend_int;
  logic [DEC_W-1:0]             pend_dec;
  cic_pkg::log2_rate_t          pend_shift_int;
  cic_pkg::log2_rate_t          pend_shift_dec;
  cic_pkg::log2_rate_t          rate_log2;
  logic                         one_hot;
  logic                         legal;

  // A legal rate has exactly one bit set, and that bit is its log2.
  assign one_hot = (cfg_rate != '0) && ((cfg_rate & (cfg_rate - 1'b1)) == '0);

  always_comb begin
    rate_log2 = '0;
    for (int b = 0; b < CFG_RATE_W; b++) begin
      if (cfg_rate[b]) begin
        rate_log2 = cic_pkg::log2_rate_t'(b);
      end
    end
  end

  always_comb begin
    case (cfg_op)
      resample_cfg_pkg::CFG_SET_INT: legal = one_hot && (cfg_rate <= MAX_RATE_INT);
      resample_cfg_pkg::CFG_SET_DEC: legal = one_hot && (cfg_rate <= MAX_RATE_DEC);
      default:                       legal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= resample_cfg_pkg::CFG_IDLE;
      rate_stb       <= 1'b0;
      pend_int       <= INT_W'(1);
      pend_dec       <= DEC_W'(1);
      pend_shift_int <= '0;
      pend_shift_dec <= '0;
      rate_int       <= INT_W'(1); // 1:1 pass-through until the first apply.
      rate_dec       <= DEC_W'(1);
      shift_int      <= '0;
      shift_dec      <= '0;
    end else begin
      rate_stb <= 1'b0;
      if (cfg_valid) begin
        case (cfg_op)
          resample_cfg_pkg::CFG_SET_INT,
          resample_cfg_pkg::CFG_SET_DEC: begin
            if (!legal) begin
              state <= resample_cfg_pkg::CFG_ERROR; // Pending value is kept.
            end else begin
              if (cfg_op == resample_cfg_pkg::CFG_SET_INT) begin
                pend_int       <= cfg_rate[INT_W-1:0];
                pend_shift_int <= rate_log2;
              end else begin
                pend_dec       <= cfg_rate[DEC_W-1:0];
                pend_shift_dec <= rate_log2;
              end
              if (state != resample_cfg_pkg::CFG_ERROR) begin
                state <= resample_cfg_pkg::CFG_PENDING;
              end
            end
          end
          resample_cfg_pkg::CFG_APPLY: begin
            // An apply in error only acknowledges the error.
            if (state != resample_cfg_pkg::CFG_ERROR) begin
              rate_int  <= pend_int;
              rate_dec  <= pend_dec;
              shift_int <= pend_shift_int;
              shift_dec <= pend_shift_dec;
              rate_stb  <= 1'b1;
            end
            state <= resample_cfg_pkg::CFG_IDLE;
          end
          default: ;
        endcase
      end
    end
  end

  assign cfg_pending = (state == resample_cfg_pkg::CFG_PENDING);
  assign cfg_error   = (state == resample_cfg_pkg::CFG_ERROR);

endmodule

// ==== hw/cic_pkg.sv ====
package cic_pkg;

  // Both filter kinds spend one cycle in FLUSH after a rate change. In
  // that cycle every integrator, comb and counter is cleared and input
  // strobes are ignored.
  typedef enum logic {
    CIC_FLUSH = 1'b0,
    CIC_RUN   = 1'b1
  } cic_phase_e;

  // Rates are powers of two, so a rate travels next to its log2.
  // Four bits cover every shift up to a rate of 256.
  localparam int LOG2_RATE_W = 4;

  typedef logic [LOG2_RATE_W-1:0] log2_rate_t;

endpackage

// ==== hw/resample_cfg_pkg.sv ====
package resample_cfg_pkg;

  // Commands accepted on the configuration port together with cfg_valid.
  // SET_INT and SET_DEC only load the pending registers. Nothing reaches
  // the filters until an APPLY arrives.
  typedef enum logic [1:0] {
    CFG_NOP     = 2'd0,
    CFG_SET_INT = 2'd1, // Load the pending interpolation rate.
    CFG_SET_DEC = 2'd2, // Load the pending decimation rate.
    CFG_APPLY   = 2'd3  // Promote pending to active and flush the filters.
  } cfg_op_e;

  // State of the rate register block.
  // IDLE means that the pending rates match what was last applied, or that
  // nothing new was written since the last apply. PENDING means that legal
  // values wait for an apply. ERROR is sticky and is left only through an
  // APPLY, which then discards the request, or through reset.
  typedef enum logic [1:0] {
    CFG_IDLE    = 2'd0,
    CFG_PENDING = 2'd1,
    CFG_ERROR   = 2'd2
  } cfg_state_e;

endpackage
